// File: common/tnn_macros.svh
`ifndef TNN_MACROS_SVH
`define TNN_MACROS_SVH

// **************************************************
// network sizes
// **************************************************

`define FEAT_CNT   8
`define FEAT_BITS  4
`define HIDDEN_CNT 6
`define CLASS_CNT  3

// a neuron sum holds plus or minus FEAT_CNT times the largest feature
`define ACC_BITS   8

// a class score holds plus or minus HIDDEN_CNT
`define SCORE_BITS 4

// **************************************************
// first layer weights
// **************************************************

// bit n*FEAT_CNT+f belongs to hidden neuron n and feature f
// a set mask bit marks a nonzero weight, the sign bit then gives plus one (1) or minus one (0)
// neuron 0 uses all eight features
// neuron 1 uses feature 4 only
// neurons 2 to 5 use four features each
//
//  neuron      5  4  3  2  1  0
`define L1_MASK 48'h96_3c_c3_69_10_ff
`define L1_SIGN 48'h84_14_82_41_10_a6

// **************************************************
// output layer weights
// **************************************************

// bit c*HIDDEN_CNT+h belongs to class c and hidden neuron h
// class 0 sees every hidden bit, classes 1 and 2 see four each
//
//  class        2      1      0
`define L2_MASK 18'b110011_011110_111111
`define L2_SIGN 18'b100010_010100_101011

`endif

// File: common/tnn_pkg.sv
`include "tnn_macros.svh"

package tnn_pkg;

  // **************************************************
  // first layer sequencer
  // **************************************************

  // idle waits for a start, accumulate walks the sparse index
  typedef enum logic {
    seq_idle,
    seq_accumulate
  } seq_state_t;

  // **************************************************
  // classification results
  // **************************************************

  // a class index is wide enough for CLASS_CNT classes
  typedef logic [1:0] class_t;

  // a class score is the signed sum of up to HIDDEN_CNT terms of plus or minus one
  typedef logic signed [`SCORE_BITS-1:0] score_t;

endpackage

// File: first_layer/first_layer.sv
`timescale 1ns/100ps
`include "tnn_macros.svh"

module first_layer import tnn_pkg::*; (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             start,
  input  logic [`FEAT_CNT*`FEAT_BITS-1:0]  features,
  output logic [`HIDDEN_CNT-1:0]           hidden,
  output logic                             hidden_valid,
  output logic                             busy
);

  // the index has to reach FEAT_CNT so that a full neuron halts too
  localparam int idx_bits = $clog2(`FEAT_CNT + 1);
  localparam int sel_bits = $clog2(`FEAT_CNT);
  localparam logic [`HIDDEN_CNT*`FEAT_CNT-1:0] l1_mask = `L1_MASK;
  localparam logic [`HIDDEN_CNT*`FEAT_CNT-1:0] l1_sign = `L1_SIGN;

  seq_state_t                      state;
  logic [idx_bits-1:0]             idx;
  logic [`FEAT_CNT*`FEAT_BITS-1:0] feat_q;
  logic                            accept;
  logic                            last_step;
  logic [`HIDDEN_CNT-1:0]          halt;
  logic signed [`FEAT_BITS:0]      sample [`HIDDEN_CNT];

  // number of nonzero weights in one neuron's mask
  function automatic int nz_count(input logic [`FEAT_CNT-1:0] m);
    int total;
    total = 0;
    for (int f = 0; f < `FEAT_CNT; f++) begin
      if (m[f]) total++;
    end
    return total;
  endfunction

  // feature position of the slot-th nonzero weight
  function automatic int nz_pos(input logic [`FEAT_CNT-1:0] m, input int slot);
    int seen;
    int pos;
    seen = 0;
    pos = 0;
    for (int f = 0; f < `FEAT_CNT; f++) begin
      if (m[f]) begin
        if (seen == slot) pos = f;
        seen++;
      end
    end
    return pos;
  endfunction

  assign accept    = start && (state == seq_idle);
  assign last_step = (state == seq_accumulate) && (idx == idx_bits'(`FEAT_CNT - 1));
  assign busy      = (state == seq_accumulate);

  // **************************************************
  // sequencer
  // **************************************************

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= seq_idle;
      idx          <= '0;
      hidden_valid <= 1'b0;
    end else begin
      hidden_valid <= last_step;
      if (accept) begin
        state <= seq_accumulate;
        idx   <= '0;
      end else if (state == seq_accumulate) begin
        idx <= idx + 1'b1;
        if (last_step) state <= seq_idle;
      end
    end
  end

  // features are only taken with an accepted start
  always_ff @(posedge clk) begin
    if (accept) feat_q <= features;
  end

  // **************************************************
  // hidden neurons
  // **************************************************

  for (genvar n = 0; n < `HIDDEN_CNT; n++) begin : g_neuron
    localparam logic [`FEAT_CNT-1:0] n_mask = l1_mask[n*`FEAT_CNT +: `FEAT_CNT];
    localparam logic [`FEAT_CNT-1:0] n_sign = l1_sign[n*`FEAT_CNT +: `FEAT_CNT];
    localparam int count = nz_count(n_mask);

    logic signed [`FEAT_BITS:0] terms [`FEAT_CNT];

    // slot s of the compacted list holds the s-th nonzero term of this neuron
    for (genvar s = 0; s < `FEAT_CNT; s++) begin : g_slot
      if (s < count) begin : g_used
        localparam int pos = nz_pos(n_mask, s);
        assign terms[s] = n_sign[pos] ?
                          $signed({1'b0, feat_q[pos*`FEAT_BITS +: `FEAT_BITS]}) :
                          -$signed({1'b0, feat_q[pos*`FEAT_BITS +: `FEAT_BITS]});
      end else begin : g_unused
        assign terms[s] = '0;
      end
    end

    assign sample[n] = terms[idx[sel_bits-1:0]];
    assign halt[n]   = !busy || (idx >= idx_bits'(count));

    neuron_accumulator u_acc (
      .clk      (clk),
      .rst      (rst),
      .clear    (accept),
      .halt     (halt[n]),
      .sample   (sample[n]),
      .sign_bit (hidden[n])
    );
  end

  // a start arriving mid-walk must leave the index running on
  a_busy_start_ignored : assert property (@(posedge clk) disable iff (rst)
    (start && busy && !last_step) |=> (busy && (idx == $past(idx) + 1'b1)));

  a_hidden_valid_single : assert property (@(posedge clk) disable iff (rst)
    hidden_valid |=> !hidden_valid);

endmodule

// File: first_layer/neuron_accumulator.sv
`timescale 1ns/100ps
`include "tnn_macros.svh"

module neuron_accumulator import tnn_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clear,
  input  logic                       halt,
  input  logic signed [`FEAT_BITS:0] sample,
  output logic                       sign_bit
);

  // largest magnitude the sequencer can build from FEAT_CNT terms
  localparam int sum_limit = `FEAT_CNT * (2 ** `FEAT_BITS - 1);

  logic signed [`ACC_BITS-1:0] sum;
  logic signed [`ACC_BITS-1:0] sample_ext;

  // sign extension of the incoming term
  assign sample_ext = sample;

  // **************************************************
  // running sum
  // **************************************************

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (!halt) begin
      sum <= sum + sample_ext;
    end
  end

  // zero counts as positive, so the hidden bit is set
  assign sign_bit = !sum[`ACC_BITS-1];

  // holds only if the first layer halts this neuron after its last nonzero weight
  a_sum_in_range : assert property (@(posedge clk) disable iff (rst)
    (sum <= sum_limit) && (sum >= -sum_limit));

endmodule

// File: sim/tnn_tb.sv
`timescale 1ns/100ps
`include "tnn_macros.svh"

module tnn_tb import tnn_pkg::*; ();

  localparam int feat_w = `FEAT_CNT * `FEAT_BITS;
  localparam int pulse_timeout = 4 * `FEAT_CNT;
  localparam int idle_timeout = 2 * `FEAT_CNT;
  // features 0 and 6 at fifteen give class scores -2, 2, 2
  localparam logic [feat_w-1:0] tie_vector = 32'h0f00_000f;

  logic                   clk;
  logic                   rst;
  logic                   start;
  logic [feat_w-1:0]      features;
  class_t                 class_id;
  logic                   result_valid;
  logic [`HIDDEN_CNT-1:0] hidden;
  logic                   hidden_valid;
  logic                   busy;
  logic                   accepted;
  seq_state_t             seq_state;

  logic [`HIDDEN_CNT-1:0] hid_q [$];
  class_t                 cls_q [$];
  int                     result_cycles [$];
  logic [`HIDDEN_CNT-1:0] exp_hidden;
  logic [`HIDDEN_CNT-1:0] accept_hidden;
  class_t                 exp_class;
  int                     hid_pending;
  int                     cls_pending;
  logic                   started;
  logic [31:0]            lfsr_state;
  int                     cycle = 0;
  int                     accepted_cnt = 0;
  int                     result_cnt = 0;
  int                     value_errors = 0;
  int                     protocol_errors = 0;
  int                     timeout_errors = 0;

  tnn_classifier dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .features     (features),
    .class_id     (class_id),
    .result_valid (result_valid),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .busy         (busy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  assign accepted  = start && !busy;
  assign seq_state = dut.u_first_layer.state;

  // **************************************************
  // reference model
  // **************************************************

  // dense walk over every weight where zero weights contribute nothing
  function automatic logic [`HIDDEN_CNT-1:0] ref_hidden(input logic [feat_w-1:0] feat);
    logic [`HIDDEN_CNT*`FEAT_CNT-1:0] mask;
    logic [`HIDDEN_CNT*`FEAT_CNT-1:0] sgn;
    logic [`HIDDEN_CNT-1:0]           h;
    int                               sum;
    int                               fv;
    mask = `L1_MASK;
    sgn  = `L1_SIGN;
    for (int n = 0; n < `HIDDEN_CNT; n++) begin
      sum = 0;
      for (int f = 0; f < `FEAT_CNT; f++) begin
        fv = feat[f*`FEAT_BITS +: `FEAT_BITS];
        if (mask[n*`FEAT_CNT + f]) sum += sgn[n*`FEAT_CNT + f] ? fv : -fv;
      end
      h[n] = (sum >= 0);
    end
    return h;
  endfunction

  function automatic score_t ref_score(input logic [`HIDDEN_CNT-1:0] h, input int c);
    logic [`CLASS_CNT*`HIDDEN_CNT-1:0] mask;
    logic [`CLASS_CNT*`HIDDEN_CNT-1:0] sgn;
    int                                sum;
    int                                term;
    mask = `L2_MASK;
    sgn  = `L2_SIGN;
    sum  = 0;
    for (int n = 0; n < `HIDDEN_CNT; n++) begin
      // the hidden bit as plus or minus one, multiplied by the weight
      term = h[n] ? 1 : -1;
      if (mask[c*`HIDDEN_CNT + n]) sum += sgn[c*`HIDDEN_CNT + n] ? term : -term;
    end
    return score_t'(sum);
  endfunction

  function automatic class_t ref_class(input logic [`HIDDEN_CNT-1:0] h);
    class_t best;
    score_t best_score;
    best       = '0;
    best_score = ref_score(h, 0);
    for (int c = 1; c < `CLASS_CNT; c++) begin
      if (ref_score(h, c) > best_score) begin
        best       = class_t'(c);
        best_score = ref_score(h, c);
      end
    end
    return best;
  endfunction

  function automatic bit has_tied_top(input logic [`HIDDEN_CNT-1:0] h);
    score_t top;
    int     hits;
    top  = ref_score(h, 0);
    hits = 0;
    for (int c = 1; c < `CLASS_CNT; c++) begin
      if (ref_score(h, c) > top) top = ref_score(h, c);
    end
    for (int c = 0; c < `CLASS_CNT; c++) begin
      if (ref_score(h, c) == top) hits++;
    end
    return hits > 1;
  endfunction

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_features(output logic [feat_w-1:0] v);
    for (int i = 0; i < feat_w; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i] = lfsr_state[0];
    end
  endtask

  // **************************************************
  // expected results in flight
  // **************************************************

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      hid_q.delete();
      cls_q.delete();
      started = 1'b0;
    end else begin
      cycle++;
      if (hidden_valid && hid_q.size() > 0) void'(hid_q.pop_front());
      if (result_valid) begin
        result_cnt++;
        result_cycles.push_back(cycle);
        if (cls_q.size() > 0) void'(cls_q.pop_front());
      end
      if (accepted) begin
        accept_hidden = ref_hidden(features);
        hid_q.push_back(accept_hidden);
        cls_q.push_back(ref_class(accept_hidden));
        accepted_cnt++;
        started = 1'b1;
      end
    end
    hid_pending = hid_q.size();
    cls_pending = cls_q.size();
    exp_hidden  = (hid_pending > 0) ? hid_q[0] : '0;
    exp_class   = (cls_pending > 0) ? cls_q[0] : '0;
  end

  // **************************************************
  // checks
  // **************************************************

  a_reset_quiet : assert property (@(posedge clk) disable iff (rst)
    !started |-> (!busy && !hidden_valid && !result_valid && class_id == '0))
    else begin
      value_errors++;
      $display("[ERROR] idle outputs expected 0 actual busy %h hidden_valid %h",
               $sampled(busy), $sampled(hidden_valid));
      $display("[ERROR] idle outputs expected 0 actual result_valid %h class_id %h",
               $sampled(result_valid), $sampled(class_id));
    end

  a_hidden_value : assert property (@(posedge clk) disable iff (rst)
    hidden_valid |-> (hidden == exp_hidden))
    else begin
      value_errors++;
      $display("[ERROR] hidden expected %h actual %h", $sampled(exp_hidden), $sampled(hidden));
    end

  a_class_value : assert property (@(posedge clk) disable iff (rst)
    result_valid |-> (class_id == exp_class))
    else begin
      value_errors++;
      $display("[ERROR] class_id expected %h actual %h",
               $sampled(exp_class), $sampled(class_id));
    end

  a_hidden_expected : assert property (@(posedge clk) disable iff (rst)
    hidden_valid |-> (hid_pending > 0))
    else begin
      protocol_errors++;
      $display("hidden_valid pulsed although no accepted start was waiting for it");
    end

  a_result_expected : assert property (@(posedge clk) disable iff (rst)
    result_valid |-> (cls_pending > 0))
    else begin
      protocol_errors++;
      $display("result_valid pulsed although no accepted start was waiting for it");
    end

  a_hidden_timing : assert property (@(posedge clk) disable iff (rst)
    accepted |=> (!hidden_valid) [*`FEAT_CNT] ##1 hidden_valid)
    else begin
      protocol_errors++;
      $display("hidden_valid did not come %0d cycles after the accepted start", `FEAT_CNT);
    end

  a_busy_length : assert property (@(posedge clk) disable iff (rst)
    accepted |=> busy [*`FEAT_CNT] ##1 !busy)
    else begin
      protocol_errors++;
      $display("busy was not high for exactly %0d cycles, sequencer in state %s",
               `FEAT_CNT, seq_state.name());
    end

  a_result_timing : assert property (@(posedge clk) disable iff (rst)
    hidden_valid |-> ##2 result_valid)
    else begin
      protocol_errors++;
      $display("result_valid did not follow hidden_valid by two cycles");
    end

  a_no_stray_result : assert property (@(posedge clk) disable iff (rst)
    result_valid |-> $past(hidden_valid, 2))
    else begin
      protocol_errors++;
      $display("result_valid pulsed without a hidden_valid two cycles before");
    end

  // **************************************************
  // stimulus
  // **************************************************

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic issue_start(input logic [feat_w-1:0] vec);
    int waited;
    waited = 0;
    while (busy && waited < idle_timeout) begin
      step();
      waited++;
    end
    if (busy) begin
      timeout_errors++;
      $display("timeout while waiting for the first layer to become idle");
    end else begin
      start    = 1'b1;
      features = vec;
      step();
      start = 1'b0;
    end
  endtask

  task automatic wait_hidden_valid();
    int waited;
    waited = 0;
    do begin
      step();
      waited++;
    end while (!hidden_valid && waited < pulse_timeout);
    if (!hidden_valid) begin
      timeout_errors++;
      $display("timeout while waiting for hidden_valid");
    end
  endtask

  // with scramble set the features keep changing while the item is in flight
  task automatic wait_result(input bit scramble);
    int                waited;
    logic [feat_w-1:0] junk;
    waited = 0;
    do begin
      step();
      waited++;
      if (scramble) begin
        random_features(junk);
        features = junk;
      end
    end while (!result_valid && waited < pulse_timeout);
    if (!result_valid) begin
      timeout_errors++;
      $display("timeout while waiting for result_valid");
    end
  endtask

  initial begin
    logic [feat_w-1:0] vec_a;
    logic [feat_w-1:0] vec_b;
    int                base;
    int                total;
    lfsr_state = 32'h87fd;
    rst        = 1'b1;
    start      = 1'b0;
    features   = '0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (4) step();

    // directed vectors
    assert (has_tied_top(ref_hidden(tie_vector)))
      else begin
        protocol_errors++;
        $display("the tie vector does not give two equal top class scores");
      end
    issue_start('0);
    wait_result(1'b0);
    issue_start({feat_w{1'b1}});
    wait_result(1'b0);
    issue_start(tie_vector);
    wait_result(1'b0);

    for (int i = 0; i < 40; i++) begin
      random_features(vec_a);
      issue_start(vec_a);
      wait_result(1'b0);
    end

    // a second start in mid-walk must be dropped
    random_features(vec_a);
    random_features(vec_b);
    issue_start(vec_a);
    repeat (3) step();
    start    = 1'b1;
    features = vec_b;
    step();
    start = 1'b0;
    wait_result(1'b1);
    repeat (2 * `FEAT_CNT) step();

    // **************************************************
    // two items in flight
    // **************************************************

    random_features(vec_a);
    random_features(vec_b);
    base = result_cycles.size();
    issue_start(vec_a);
    wait_hidden_valid();
    start    = 1'b1;
    features = vec_b;
    step();
    start = 1'b0;
    wait_result(1'b0);
    wait_result(1'b0);
    step();
    if (result_cycles.size() >= base + 2) begin
      assert (result_cycles[base+1] - result_cycles[base] == `FEAT_CNT + 1)
        else begin
          protocol_errors++;
          $display("two results in flight came %0d cycles apart instead of %0d",
                   result_cycles[base+1] - result_cycles[base], `FEAT_CNT + 1);
        end
    end

    repeat (2 * `FEAT_CNT) step();
    assert (accepted_cnt == result_cnt)
      else begin
        protocol_errors++;
        $display("%0d starts were accepted but %0d results came out", accepted_cnt, result_cnt);
      end

    total = value_errors + protocol_errors + timeout_errors;
    $display("errors: value %0d, protocol %0d, timeout %0d",
             value_errors, protocol_errors, timeout_errors);
    if (total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: source/class_argmax.sv
`timescale 1ns/100ps
`include "tnn_macros.svh"

module class_argmax import tnn_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  score_t scores [`CLASS_CNT],
  input  logic   scores_valid,
  output class_t class_id,
  output logic   result_valid
);

  class_t best_id;
  score_t best_score;

  // only a strictly greater score replaces the leader, so ties keep the lower index
  always_comb begin
    best_id    = '0;
    best_score = scores[0];
    for (int c = 1; c < `CLASS_CNT; c++) begin
      if (scores[c] > best_score) begin
        best_id    = class_t'(c);
        best_score = scores[c];
      end
    end
  end

  // **************************************************
  // result register
  // **************************************************

  // class_id stays put between results
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      class_id     <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= scores_valid;
      if (scores_valid) class_id <= best_id;
    end
  end

  a_class_in_range : assert property (@(posedge clk) disable iff (rst)
    class_id < `CLASS_CNT);

endmodule

// File: source/output_layer.sv
`timescale 1ns/100ps
`include "tnn_macros.svh"

module output_layer import tnn_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`HIDDEN_CNT-1:0] hidden,
  input  logic                   hidden_valid,
  output score_t                 scores [`CLASS_CNT],
  output logic                   scores_valid
);

  localparam logic [`CLASS_CNT*`HIDDEN_CNT-1:0] l2_mask = `L2_MASK;
  localparam logic [`CLASS_CNT*`HIDDEN_CNT-1:0] l2_sign = `L2_SIGN;
  localparam score_t one = score_t'(1);

  score_t score_d [`CLASS_CNT];

  // **************************************************
  // ternary class sums
  // **************************************************

  // a hidden bit stands for plus one when set and minus one when clear
  // the term is plus one exactly when the bit agrees with the weight sign
  always_comb begin
    for (int c = 0; c < `CLASS_CNT; c++) begin
      score_d[c] = '0;
      for (int h = 0; h < `HIDDEN_CNT; h++) begin
        if (l2_mask[c*`HIDDEN_CNT + h]) begin
          if (hidden[h] == l2_sign[c*`HIDDEN_CNT + h]) begin
            score_d[c] = score_d[c] + one;
          end else begin
            score_d[c] = score_d[c] - one;
          end
        end
      end
    end
  end

  // **************************************************
  // score register
  // **************************************************

  always_ff @(posedge clk) begin
    if (hidden_valid) scores <= score_d;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scores_valid <= 1'b0;
    end else begin
      scores_valid <= hidden_valid;
    end
  end

  a_scores_after_hidden : assert property (@(posedge clk) disable iff (rst)
    hidden_valid |=> scores_valid);

  a_no_stray_scores : assert property (@(posedge clk) disable iff (rst)
    scores_valid |-> $past(hidden_valid));

endmodule

// File: source/tnn_classifier.sv
`timescale 1ns/100ps
`include "tnn_macros.svh"

module tnn_classifier import tnn_pkg::*; (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic [`FEAT_CNT*`FEAT_BITS-1:0] features,
  output class_t                          class_id,
  output logic                            result_valid,
  output logic [`HIDDEN_CNT-1:0]          hidden,
  output logic                            hidden_valid,
  output logic                            busy
);

  score_t scores [`CLASS_CNT];
  logic   scores_valid;

  // sparse first layer, serial over the nonzero weights
  first_layer u_first_layer (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .features     (features),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .busy         (busy)
  );

  output_layer u_output_layer (
    .clk          (clk),
    .rst          (rst),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .scores       (scores),
    .scores_valid (scores_valid)
  );

  class_argmax u_class_argmax (
    .clk          (clk),
    .rst          (rst),
    .scores       (scores),
    .scores_valid (scores_valid),
    .class_id     (class_id),
    .result_valid (result_valid)
  );

endmodule

// File: verilog.f
+incdir+common
common/tnn_pkg.sv
first_layer/neuron_accumulator.sv
first_layer/first_layer.sv
source/output_layer.sv
source/class_argmax.sv
source/tnn_classifier.sv
sim/tnn_tb.sv
